// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -j 0 --top-module tb_wb_top -f flist.f -o sim_wb
	./obj_dir/sim_wb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== flist.f ====
rtl/wb_pkg.sv
rtl/csr_if.sv
rtl/wb_stage.sv
rtl/csr_file.sv
rtl/reg_file.sv
rtl/wb_top.sv
verification/tb_wb_top.sv

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
    input  logic        clk,
    input  logic        rst_n,
    csr_if.csrs         csr,
    output logic [31:0] era_pc,
    output logic [31:0] ex_entry,
    output logic [1:0]  plv
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] badv;
    logic [31:0] eentry;
    logic [31:0] save0;
    logic [31:0] rd_value;
    logic        addr_fault;

    function automatic logic [31:0] merge(
        input logic [31:0] old_value,
        input logic [31:0] new_value,
        input logic [31:0] mask
    );
        merge = (old_value & ~mask) | (new_value & mask);
    endfunction

    always_comb begin
        case (csr.num)
            wb_pkg::csr_crmd:   rd_value = crmd;
            wb_pkg::csr_prmd:   rd_value = prmd;
            wb_pkg::csr_estat:  rd_value = estat;
            wb_pkg::csr_era:    rd_value = era;
            wb_pkg::csr_badv:   rd_value = badv;
            wb_pkg::csr_eentry: rd_value = eentry;
            wb_pkg::csr_save0:  rd_value = save0;
            default:            rd_value = 32'h0;
        endcase
    end

    assign csr.rvalue = csr.re ? rd_value : 32'h0;

    // only address faults leave a bad address behind
    assign addr_fault = (csr.ecode == wb_pkg::ecode_adef) || (csr.ecode == wb_pkg::ecode_ale);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd   <= 32'h0;
            prmd   <= 32'h0;
            estat  <= 32'h0;
            era    <= 32'h0;
            badv   <= 32'h0;
            eentry <= 32'h0;
            save0  <= 32'h0;
        end else if (csr.ex) begin
            prmd[2:0]   <= crmd[2:0]; // save plv and ie
            crmd[2:0]   <= 3'b000; // enter kernel with interrupts off
            estat[21:16] <= csr.ecode;
            estat[30:22] <= csr.esubcode;
            era         <= csr.pc;
            if (addr_fault) begin
                badv <= (csr.ecode == wb_pkg::ecode_adef) ? csr.pc : csr.vaddr;
            end
        end else if (csr.ertn) begin
            crmd[2:0] <= prmd[2:0];
        end else if (csr.we) begin
            case (csr.num)
                wb_pkg::csr_crmd: begin
                    crmd <= merge(crmd, csr.wvalue, csr.wmask & wb_pkg::crmd_wmask);
                end
                wb_pkg::csr_prmd: begin
                    prmd <= merge(prmd, csr.wvalue, csr.wmask & wb_pkg::prmd_wmask);
                end
                wb_pkg::csr_estat: begin
                    estat <= merge(estat, csr.wvalue, csr.wmask & wb_pkg::estat_wmask);
                end
                wb_pkg::csr_era: begin
                    era <= merge(era, csr.wvalue, csr.wmask);
                end
                wb_pkg::csr_badv: begin
                    badv <= merge(badv, csr.wvalue, csr.wmask);
                end
                wb_pkg::csr_eentry: begin
                    eentry <= merge(eentry, csr.wvalue, csr.wmask & wb_pkg::eentry_wmask);
                end
                wb_pkg::csr_save0: begin
                    save0 <= merge(save0, csr.wvalue, csr.wmask);
                end
                default: begin
                    save0 <= save0; // writes to unknown numbers are ignored
                end
            endcase
        end
    end

    assign csr.plv  = crmd[1:0];
    assign plv      = crmd[1:0];
    assign era_pc   = era;
    assign ex_entry = eentry;

endmodule

// ==== rtl/csr_if.sv ====
`timescale 1ns/1ps

interface csr_if;

    logic                            re;
    logic [wb_pkg::csr_num_w-1:0]    num;
    logic [31:0]                     rvalue;
    logic                            we;
    logic [31:0]                     wmask;
    logic [31:0]                     wvalue;

    logic                            ex;
    logic [wb_pkg::ecode_w-1:0]      ecode;
    logic [wb_pkg::esubcode_w-1:0]   esubcode;
    logic [31:0]                     pc;
    logic [31:0]                     vaddr;
    logic                            ertn;
    logic [1:0]                      plv;

    modport stage (
        output re, num, we, wmask, wvalue, ex, ecode, esubcode, pc, vaddr, ertn,
        input  rvalue, plv
    );

    modport csrs (
        input  re, num, we, wmask, wvalue, ex, ecode, esubcode, pc, vaddr, ertn,
        output rvalue, plv
    );

endinterface

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr,
    output logic [31:0] rdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata; // r0 is hardwired to zero
        end
    end

    assign rdata = (raddr == 5'd0) ? 32'h0 : regs[raddr];

endmodule

// ==== rtl/wb_pkg.sv ====
package wb_pkg;

    localparam int csr_num_w  = 14;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;
    localparam int ex_w       = 6;

    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h000;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h001;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h005;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h006;
    localparam logic [csr_num_w-1:0] csr_badv   = 14'h007;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'h00c;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h030;

    localparam logic [ecode_w-1:0] ecode_int  = 6'h00;
    localparam logic [ecode_w-1:0] ecode_adef = 6'h08;
    localparam logic [ecode_w-1:0] ecode_ale  = 6'h09;
    localparam logic [ecode_w-1:0] ecode_sys  = 6'h0b;
    localparam logic [ecode_w-1:0] ecode_brk  = 6'h0c;
    localparam logic [ecode_w-1:0] ecode_ine  = 6'h0d;

    // flag positions in the exception vector with int on top
    localparam int ex_bit_int  = 5;
    localparam int ex_bit_sys  = 4;
    localparam int ex_bit_brk  = 3;
    localparam int ex_bit_adef = 2;
    localparam int ex_bit_ale  = 1;
    localparam int ex_bit_ine  = 0;

    localparam logic [31:0] crmd_wmask   = 32'h0000_0007; // plv and ie
    localparam logic [31:0] prmd_wmask   = 32'h0000_0007; // pplv and pie
    localparam logic [31:0] estat_wmask  = 32'h0000_0003; // software interrupt bits
    localparam logic [31:0] eentry_wmask = 32'hffff_ffc0; // entry is 64-byte aligned

endpackage

// ==== rtl/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [31:0]                  in_pc,
    input  logic [4:0]                   in_dest,
    input  logic [31:0]                  in_result,
    input  logic                         in_gr_we,
    input  logic [wb_pkg::ex_w-1:0]      in_ex,
    input  logic                         in_ertn,
    input  logic                         in_op_csr,
    input  logic [wb_pkg::csr_num_w-1:0] in_csr_num,
    input  logic [31:0]                  in_csr_wmask,
    input  logic [4:0]                   in_rj,
    input  logic                         in_rdcntid,
    output logic                         allow_in,
    output logic                         rf_we,
    output logic [4:0]                   rf_waddr,
    output logic [31:0]                  rf_wdata,
    output logic [31:0]                  debug_pc,
    output logic [4:0]                   fwd_dest,
    output logic [31:0]                  fwd_data,
    output logic                         fwd_op_csr,
    output logic                         ex_flush,
    output logic                         ertn_flush,
    csr_if.stage                         csr
);

    logic                         valid;
    logic                         ready_go;
    logic [31:0]                  pc_r;
    logic [4:0]                   dest_r;
    logic [31:0]                  result_r;
    logic                         gr_we_r;
    logic [wb_pkg::ex_w-1:0]      ex_r;
    logic                         ertn_r;
    logic                         op_csr_r;
    logic [wb_pkg::csr_num_w-1:0] csr_num_r;
    logic [31:0]                  csr_wmask_r;
    logic [4:0]                   rj_r;
    logic                         rdcntid_r;

    assign ready_go = 1'b1; // writeback has nothing to wait for
    assign allow_in = ~valid | ready_go;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (ex_flush) begin
            valid <= 1'b0; // whatever arrives behind a flush is discarded
        end else if (allow_in) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allow_in) begin
            pc_r        <= in_pc;
            dest_r      <= in_dest;
            result_r    <= in_result;
            gr_we_r     <= in_gr_we;
            ex_r        <= in_ex;
            ertn_r      <= in_ertn;
            op_csr_r    <= in_op_csr;
            csr_num_r   <= in_csr_num;
            csr_wmask_r <= in_csr_wmask;
            rj_r        <= in_rj;
            rdcntid_r   <= in_rdcntid;
        end
    end

    assign ex_flush   = valid && ((|ex_r) || ertn_r);
    assign ertn_flush = valid && ertn_r && (csr.plv == 2'b00);

    assign csr.ex    = valid && (|ex_r); // ertn is committed separately
    assign csr.ertn  = ertn_flush;
    assign csr.ecode = ex_r[wb_pkg::ex_bit_sys]  ? wb_pkg::ecode_sys  :
                       ex_r[wb_pkg::ex_bit_brk]  ? wb_pkg::ecode_brk  :
                       ex_r[wb_pkg::ex_bit_adef] ? wb_pkg::ecode_adef :
                       ex_r[wb_pkg::ex_bit_ale]  ? wb_pkg::ecode_ale  :
                       ex_r[wb_pkg::ex_bit_ine]  ? wb_pkg::ecode_ine  :
                                                   wb_pkg::ecode_int;
    assign csr.esubcode = '0;
    assign csr.pc       = pc_r;
    assign csr.vaddr    = result_r; // the faulting address rides in the result

    assign csr.re     = valid && op_csr_r;
    assign csr.num    = csr_num_r;
    assign csr.we     = csr.re && !rdcntid_r && (rj_r != 5'd0) && !ex_flush;
    assign csr.wmask  = (rj_r == 5'd1) ? 32'hffff_ffff : csr_wmask_r; // csrwr form
    assign csr.wvalue = result_r;

    assign rf_we    = valid && gr_we_r && !ex_flush;
    assign rf_waddr = dest_r;
    assign rf_wdata = csr.re ? csr.rvalue : result_r;

    assign debug_pc = pc_r;

    assign fwd_dest   = dest_r & {5{valid}};
    assign fwd_data   = rf_wdata;
    assign fwd_op_csr = op_csr_r && valid;

endmodule

// ==== rtl/wb_top.sv ====
`timescale 1ns/1ps

module wb_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         mem_to_wb_valid,
    input  logic [31:0]                  in_pc,
    input  logic [4:0]                   in_dest,
    input  logic [31:0]                  in_result,
    input  logic                         in_gr_we,
    input  logic [wb_pkg::ex_w-1:0]      in_ex,
    input  logic                         in_ertn,
    input  logic                         in_op_csr,
    input  logic [wb_pkg::csr_num_w-1:0] in_csr_num,
    input  logic [31:0]                  in_csr_wmask,
    input  logic [4:0]                   in_rj,
    input  logic                         in_rdcntid,
    input  logic [4:0]                   rf_raddr,
    output logic                         wb_allow_in,
    output logic [31:0]                  rf_rdata,
    output logic [31:0]                  debug_wb_pc,
    output logic [3:0]                   debug_wb_rf_we,
    output logic [4:0]                   debug_wb_rf_wnum,
    output logic [31:0]                  debug_wb_rf_wdata,
    output logic [4:0]                   wb_forward_dest,
    output logic [31:0]                  wb_forward_data,
    output logic                         wb_forward_op_csr,
    output logic                         wb_ex_flush,
    output logic                         ertn_flush,
    output logic [31:0]                  era_pc,
    output logic [31:0]                  ex_entry,
    output logic [1:0]                   csr_plv_out
);

    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    csr_if i_csr_if ();

    wb_stage i_wb_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (mem_to_wb_valid),
        .in_pc        (in_pc),
        .in_dest      (in_dest),
        .in_result    (in_result),
        .in_gr_we     (in_gr_we),
        .in_ex        (in_ex),
        .in_ertn      (in_ertn),
        .in_op_csr    (in_op_csr),
        .in_csr_num   (in_csr_num),
        .in_csr_wmask (in_csr_wmask),
        .in_rj        (in_rj),
        .in_rdcntid   (in_rdcntid),
        .allow_in     (wb_allow_in),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .rf_wdata     (rf_wdata),
        .debug_pc     (debug_wb_pc),
        .fwd_dest     (wb_forward_dest),
        .fwd_data     (wb_forward_data),
        .fwd_op_csr   (wb_forward_op_csr),
        .ex_flush     (wb_ex_flush),
        .ertn_flush   (ertn_flush),
        .csr          (i_csr_if.stage)
    );

    csr_file i_csr_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .csr      (i_csr_if.csrs),
        .era_pc   (era_pc),
        .ex_entry (ex_entry),
        .plv      (csr_plv_out)
    );

    reg_file i_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

    assign debug_wb_rf_we    = {4{rf_we}}; // one enable per byte lane
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// ==== verification/tb_wb_top.sv ====
`timescale 1ns/1ps

module tb_wb_top;

    logic                         clk = 1'b0;
    logic                         rst_n;
    logic                         mem_to_wb_valid;
    logic [31:0]                  in_pc;
    logic [4:0]                   in_dest;
    logic [31:0]                  in_result;
    logic                         in_gr_we;
    logic [wb_pkg::ex_w-1:0]      in_ex;
    logic                         in_ertn;
    logic                         in_op_csr;
    logic [wb_pkg::csr_num_w-1:0] in_csr_num;
    logic [31:0]                  in_csr_wmask;
    logic [4:0]                   in_rj;
    logic                         in_rdcntid;
    logic [4:0]                   rf_raddr;
    logic                         wb_allow_in;
    logic [31:0]                  rf_rdata;
    logic [31:0]                  debug_wb_pc;
    logic [3:0]                   debug_wb_rf_we;
    logic [4:0]                   debug_wb_rf_wnum;
    logic [31:0]                  debug_wb_rf_wdata;
    logic [4:0]                   wb_forward_dest;
    logic [31:0]                  wb_forward_data;
    logic                         wb_forward_op_csr;
    logic                         wb_ex_flush;
    logic                         ertn_flush;
    logic [31:0]                  era_pc;
    logic [31:0]                  ex_entry;
    logic [1:0]                   csr_plv_out;

    // copy of the item in flight for the reference model
    logic [31:0] it_pc;
    logic [4:0]  it_dest;
    logic [31:0] it_result;
    logic        it_gr_we;
    logic [5:0]  it_ex;
    logic        it_ertn;
    logic        it_op_csr;
    logic [13:0] it_num;
    logic [31:0] it_wmask;
    logic [4:0]  it_rj;
    logic        it_rdcntid;

    logic [31:0] m_regs [32];
    logic [31:0] m_crmd;
    logic [31:0] m_prmd;
    logic [31:0] m_estat;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [31:0] m_eentry;
    logic [31:0] m_save0;
    logic        exp_rf_we;
    logic        exp_ex_flush;
    logic        exp_ertn_flush;
    logic [31:0] exp_wdata;
    logic [31:0] rnd;
    logic [31:0] rnd2;
    event        item_taken;

    wb_top i_dut (.*);

    always #4 clk = ~clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("Mismatch %s exp 0x%08h got 0x%08h", name, exp, got);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] csr_value(input logic [13:0] num);
        case (num)
            wb_pkg::csr_crmd:   csr_value = m_crmd;
            wb_pkg::csr_prmd:   csr_value = m_prmd;
            wb_pkg::csr_estat:  csr_value = m_estat;
            wb_pkg::csr_era:    csr_value = m_era;
            wb_pkg::csr_badv:   csr_value = m_badv;
            wb_pkg::csr_eentry: csr_value = m_eentry;
            wb_pkg::csr_save0:  csr_value = m_save0;
            default:            csr_value = 32'h0;
        endcase
    endfunction

    // predicts the writeback of one item and advances the model state
    function automatic void ref_retire();
        logic        ex;
        logic [31:0] m;
        logic [31:0] v;
        logic [5:0]  ecode;
        ex = |it_ex;
        exp_ex_flush = ex || it_ertn;
        exp_ertn_flush = it_ertn && (m_crmd[1:0] == 2'b00);
        exp_wdata = it_op_csr ? csr_value(it_num) : it_result;
        exp_rf_we = it_gr_we && !exp_ex_flush;
        m = (it_rj == 5'd1) ? 32'hffff_ffff : it_wmask;
        v = it_result;
        ecode = it_ex[4] ? wb_pkg::ecode_sys  : it_ex[3] ? wb_pkg::ecode_brk :
                it_ex[2] ? wb_pkg::ecode_adef : it_ex[1] ? wb_pkg::ecode_ale :
                it_ex[0] ? wb_pkg::ecode_ine  : wb_pkg::ecode_int;
        if (ex) begin
            m_prmd[2:0] = m_crmd[2:0];
            m_crmd[2:0] = 3'b000;
            m_estat[21:16] = ecode;
            m_estat[30:22] = 9'h0;
            m_era = it_pc;
            if (ecode == wb_pkg::ecode_adef) m_badv = it_pc;
            if (ecode == wb_pkg::ecode_ale) m_badv = it_result;
        end else if (exp_ertn_flush) begin
            m_crmd[2:0] = m_prmd[2:0];
        end else if (it_op_csr && it_rj != 5'd0 && !it_rdcntid && !exp_ex_flush) begin
            case (it_num)
                wb_pkg::csr_crmd:   m &= wb_pkg::crmd_wmask;
                wb_pkg::csr_prmd:   m &= wb_pkg::prmd_wmask;
                wb_pkg::csr_estat:  m &= wb_pkg::estat_wmask;
                wb_pkg::csr_eentry: m &= wb_pkg::eentry_wmask;
                default:            m = m;
            endcase
            case (it_num)
                wb_pkg::csr_crmd:   m_crmd   = (m_crmd & ~m) | (v & m);
                wb_pkg::csr_prmd:   m_prmd   = (m_prmd & ~m) | (v & m);
                wb_pkg::csr_estat:  m_estat  = (m_estat & ~m) | (v & m);
                wb_pkg::csr_era:    m_era    = (m_era & ~m) | (v & m);
                wb_pkg::csr_badv:   m_badv   = (m_badv & ~m) | (v & m);
                wb_pkg::csr_eentry: m_eentry = (m_eentry & ~m) | (v & m);
                wb_pkg::csr_save0:  m_save0  = (m_save0 & ~m) | (v & m);
                default:            m = m;
            endcase
        end
        if (exp_rf_we && it_dest != 5'd0) m_regs[it_dest] = exp_wdata;
    endfunction

    // stage outputs in the cycle after the item is taken, committed state one edge later
    always begin
        @(item_taken);
        @(negedge clk);
        ref_retire();
        check("wb_allow_in", 32'h1, {31'h0, wb_allow_in});
        check("debug_wb_rf_we", {28'h0, {4{exp_rf_we}}}, {28'h0, debug_wb_rf_we});
        check("debug_wb_pc", it_pc, debug_wb_pc);
        check("debug_wb_rf_wnum", {27'h0, it_dest}, {27'h0, debug_wb_rf_wnum});
        check("debug_wb_rf_wdata", exp_wdata, debug_wb_rf_wdata);
        check("wb_forward_data", exp_wdata, wb_forward_data);
        check("wb_forward_dest", {27'h0, it_dest}, {27'h0, wb_forward_dest});
        check("wb_forward_op_csr", {31'h0, it_op_csr}, {31'h0, wb_forward_op_csr});
        check("wb_ex_flush", {31'h0, exp_ex_flush}, {31'h0, wb_ex_flush});
        check("ertn_flush", {31'h0, exp_ertn_flush}, {31'h0, ertn_flush});
        @(negedge clk);
        check("rf_rdata", m_regs[rf_raddr], rf_rdata);
        check("csr_plv_out", {30'h0, m_crmd[1:0]}, {30'h0, csr_plv_out});
        check("era_pc", m_era, era_pc);
        check("ex_entry", m_eentry, ex_entry);
    end

    task automatic wait_allow_in();
        int cycles;
        cycles = 0;
        while (!wb_allow_in) begin
            @(posedge clk);
            cycles++;
            if (cycles > 50) begin
                $display("Timeout: the writeback stage never accepted an item");
                $display("Simulation failed");
                $fatal(1);
            end
        end
    endtask

    // follow offers a second item right behind, which an exception must drop
    task automatic offer(input logic [31:0] pc, input logic [4:0] dest, input logic [31:0] result,
                         input logic gr_we, input logic [5:0] ex, input logic ertn,
                         input logic op_csr, input logic [13:0] num, input logic [31:0] wmask,
                         input logic [4:0] rj, input logic rdcntid, input logic follow);
        @(posedge clk);
        wait_allow_in();
        {it_pc, it_dest, it_result, it_gr_we, it_ex, it_ertn} = {pc, dest, result, gr_we, ex, ertn};
        {it_op_csr, it_num, it_wmask, it_rj, it_rdcntid} = {op_csr, num, wmask, rj, rdcntid};
        mem_to_wb_valid <= 1'b1;
        in_pc <= pc;
        in_dest <= dest;
        in_result <= result;
        in_gr_we <= gr_we;
        in_ex <= ex;
        in_ertn <= ertn;
        in_op_csr <= op_csr;
        in_csr_num <= num;
        in_csr_wmask <= wmask;
        in_rj <= rj;
        in_rdcntid <= rdcntid;
        rf_raddr <= dest;
        @(posedge clk);
        -> item_taken;
        mem_to_wb_valid <= follow;
        if (follow) begin
            in_dest <= 5'd7;
            in_result <= 32'hdead_0007;
            in_gr_we <= 1'b1;
            {in_ex, in_ertn, in_op_csr} <= '0;
        end
        @(posedge clk);
        mem_to_wb_valid <= 1'b0;
        @(posedge clk);
    endtask

    task automatic csr_op(input logic [13:0] num, input logic [31:0] value,
                          input logic [31:0] wmask, input logic [4:0] rj, input logic rdcntid);
        offer(32'h1c00_0100, 5'd4, value, 1'b1, 6'h0, 1'b0, 1'b1, num, wmask, rj, rdcntid, 1'b0);
    endtask

    task automatic read_reg(input logic [4:0] r);
        @(posedge clk);
        rf_raddr <= r;
        @(negedge clk);
        check("rf_rdata", m_regs[r], rf_rdata);
    endtask

    initial begin
        void'($urandom(13911));
        for (int i = 0; i < 32; i++) m_regs[i] = 32'h0;
        {m_crmd, m_prmd, m_estat, m_era, m_badv, m_eentry, m_save0} = '0;
        rst_n = 1'b0;
        {mem_to_wb_valid, in_pc, in_dest, in_result, in_gr_we, in_ex, in_ertn} = '0;
        {in_op_csr, in_csr_num, in_csr_wmask, in_rj, in_rdcntid, rf_raddr} = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("debug_wb_rf_we", 32'h0, {28'h0, debug_wb_rf_we});
        check("wb_ex_flush", 32'h0, {31'h0, wb_ex_flush});
        check("ertn_flush", 32'h0, {31'h0, ertn_flush});
        check("wb_forward_op_csr", 32'h0, {31'h0, wb_forward_op_csr});
        check("csr_plv_out", 32'h0, {30'h0, csr_plv_out});

        for (int i = 0; i < 40; i++) begin
            rnd = $urandom;
            rnd2 = $urandom;
            offer({rnd2[31:2], 2'b00}, rnd[4:0], $urandom, rnd[7:5] != 3'd0, 6'h0, 1'b0,
                  1'b0, 14'h0, 32'h0, 5'd0, 1'b0, 1'b0);
        end
        offer(32'h1c00_0000, 5'd0, 32'h1234_5678, 1'b1, 6'h0, 1'b0, 1'b0, 14'h0, 32'h0, 5'd0,
              1'b0, 1'b0);
        offer(32'h1c00_0004, 5'd9, 32'h5555_aaaa, 1'b0, 6'h0, 1'b0, 1'b0, 14'h0, 32'h0, 5'd0,
              1'b0, 1'b0);

        csr_op(wb_pkg::csr_save0, 32'h1357_9bdf, 32'h0, 5'd1, 1'b0);
        csr_op(wb_pkg::csr_save0, 32'hffff_0000, 32'hff00_ff00, 5'd2, 1'b0);
        csr_op(wb_pkg::csr_save0, 32'hffff_ffff, 32'hffff_ffff, 5'd0, 1'b0);
        csr_op(wb_pkg::csr_save0, 32'hffff_ffff, 32'hffff_ffff, 5'd3, 1'b1);
        csr_op(wb_pkg::csr_eentry, 32'hffff_ffff, 32'h0, 5'd1, 1'b0);
        csr_op(wb_pkg::csr_eentry, 32'h0000_0000, 32'h0f0f_0f0f, 5'd5, 1'b0);
        csr_op(wb_pkg::csr_era, 32'h8000_1000, 32'h0, 5'd1, 1'b0);
        csr_op(wb_pkg::csr_save0, 32'h0, 32'h0, 5'd0, 1'b0);

        for (int k = 0; k < 6; k++) begin
            csr_op(wb_pkg::csr_crmd, 32'h7, 32'h0, 5'd1, 1'b0);
            rnd = $urandom;
            offer({rnd[31:2], 2'b00}, 5'd12, $urandom, 1'b1, 6'(1 << k), 1'b0, 1'b0, 14'h0,
                  32'h0, 5'd0, 1'b0, 1'b1);
            read_reg(5'd7);
            csr_op(wb_pkg::csr_estat, 32'h0, 32'h0, 5'd0, 1'b0);
            csr_op(wb_pkg::csr_badv, 32'h0, 32'h0, 5'd0, 1'b0);
        end

        csr_op(wb_pkg::csr_crmd, 32'h3, 32'h0, 5'd1, 1'b0);
        offer(32'h1c00_0200, 5'd3, 32'h0, 1'b1, 6'h10, 1'b0, 1'b0, 14'h0, 32'h0, 5'd0, 1'b0,
              1'b0);
        offer(32'h1c00_0300, 5'd3, 32'h0, 1'b0, 6'h0, 1'b1, 1'b0, 14'h0, 32'h0, 5'd0, 1'b0,
              1'b0);
        offer(32'h1c00_0304, 5'd3, 32'h0, 1'b0, 6'h0, 1'b1, 1'b0, 14'h0, 32'h0, 5'd0, 1'b0,
              1'b0);

        // a bubble leaves nothing behind in the forward path
        @(negedge clk);
        check("csr_plv_out", 32'h3, {30'h0, csr_plv_out});
        check("wb_forward_dest", 32'h0, {27'h0, wb_forward_dest});
        check("debug_wb_rf_we", 32'h0, {28'h0, debug_wb_rf_we});
        csr_op(wb_pkg::csr_eentry, 32'h1c00_8040, 32'h0, 5'd1, 1'b0);
        @(negedge clk);
        check("ex_entry", 32'h1c00_8040, ex_entry);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
